/* project.f */
verilog/renamePkg.sv
verilog/renameAlloc.sv
verilog/reorderFifo.sv
verilog/regState.sv
verilog/commitUnit.sv
verilog/commitCore.sv
verification/commitCoreTb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := commitCoreTb
FILELIST := project.f
BUILD    := obj_dir
PASS     := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fail unless the pass line is printed"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(BUILD)

/* verification/commitCoreTb.sv */
// Dispatch stays within credits and writebacks hit only copies in flight; no data values.
module commitCoreTb;
	import renamePkg::*;

	localparam int WAIT_LIMIT = 60;
	localparam int NUM_STEPS = 19;

	// In-flight entry as the model sees it.
	typedef struct packed {
		regIdxT  rg;
		copyIdxT cp;
		pcT      pc;
		logic    br;
		logic    st;
		logic    misp;
		logic    done;
	} entryT;

	// Row: test, register, PC, branch, store, mispredict, async, drain, expected abort.
	typedef struct packed {
		logic [3:0] test;
		regIdxT     rg;
		pcT         pc;
		logic       br;
		logic       st;
		logic       misp;
		logic       exc;
		logic       drain;
		logic       expAbort;
	} stepT;

	logic    clk, rstN, dispatchValid, dispatchBranch, dispatchStore;
	pcT      dispatchPc, commitPc;
	regIdxT  dispatchReg, wbReg, commitReg;
	copyIdxT wbCopy, dispatchCopy, commitCopy;
	logic    wbValid, isMisPredict, isAsynExcept;
	logic    creditReturn, commitValid, commitAbort, suReady;

	// ##############################
	// Model state.
	// ##############################

	entryT       robModel[$];
	copyIdxT     modelCommitted [ARCH_REGS];
	copyMaskT    modelInUse [ARCH_REGS];
	stepT        steps [NUM_STEPS];
	logic [31:0] lfsr;
	logic        flushCycle, hung, dispatchMisp;
	int          credits, errors, commits, aborts, testErrors, testCommits, testAborts;
	int          curTest, abortsBefore;

	commitCore dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1; one step per bit taken.
	function automatic int takeBits(int n);
		int   v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	// Lowest copy of a register that neither the committed state nor a flight entry holds.
	function automatic copyIdxT lowestFree(regIdxT r);
		for (int i = 0; i < COPIES; i++) begin
			if (!modelInUse[r][i]) return copyIdxT'(i);
		end
		return '0;
	endfunction

	// Random in-flight entry still waiting for its writeback, or -1.
	function automatic int pickPending();
		int cand[$];
		for (int i = 0; i < robModel.size(); i++) begin
			if (!robModel[i].done) cand.push_back(i);
		end
		if (cand.size() == 0) return -1;
		return cand[takeBits(2) % cand.size()];
	endfunction

	task automatic reportError(string msg);
		$display("error at %0t: %s", $time, msg);
		errors++;
		testErrors++;
	endtask

	task automatic markTimeout(string what);
		$display("Timeout in test %0d: %s never happened.", curTest, what);
		hung = 1'b1;
	endtask

	task automatic driveWriteback(int idx);
		wbValid = 1'b1;
		wbReg = robModel[idx].rg;
		wbCopy = robModel[idx].cp;
	endtask

	// ##############################
	// One clock cycle.
	// ##############################

	// Checks outputs mid-cycle, updates the model for the coming edge, then idles inputs.
	task automatic tick();
		entryT   head;
		entryT   e;
		copyIdxT expCopy;
		logic    headReady;
		logic    expAbort;
		logic    expCommit;
		@(negedge clk);
		head = '0;
		if (robModel.size() > 0) head = robModel[0];
		headReady = (robModel.size() > 0) && head.done;
		expAbort = isAsynExcept || (headReady && head.br && isMisPredict);
		expCommit = headReady && !expAbort && !flushCycle;
		expCopy = lowestFree(dispatchReg);
		if (dispatchValid && dispatchCopy !== expCopy)
			reportError($sformatf("reg %0d got copy %0d, expected %0d",
				dispatchReg, dispatchCopy, expCopy));
		if (commitAbort !== expAbort)
			reportError($sformatf("commitAbort %b, expected %b", commitAbort, expAbort));
		if (commitValid !== expCommit)
			reportError($sformatf("commitValid %b, expected %b", commitValid, expCommit));
		if (expCommit && (commitPc !== head.pc || commitReg !== head.rg || commitCopy !== head.cp))
			reportError($sformatf("commit pc %0h reg %0d copy %0d, expected %0h %0d %0d",
				commitPc, commitReg, commitCopy, head.pc, head.rg, head.cp));
		if (suReady !== (expCommit && head.st))
			reportError($sformatf("suReady %b, expected %b", suReady, expCommit && head.st));
		if (creditReturn !== expCommit)
			reportError($sformatf("creditReturn %b, expected %b", creditReturn, expCommit));
		// Sender credit counter.
		if (creditReturn) credits++;
		if (commitAbort) credits = ROB_DEPTH;
		else if (dispatchValid) credits--;
		// Commit moves the committed copy and frees the old one.
		if (expCommit) begin
			modelInUse[head.rg][modelCommitted[head.rg]] = 1'b0;
			modelCommitted[head.rg] = head.cp;
			void'(robModel.pop_front());
			commits++;
			testCommits++;
		end
		if (expAbort) begin
			robModel.delete();
			for (int r = 0; r < ARCH_REGS; r++) modelInUse[r] = copyMaskT'(1) << modelCommitted[r];
			aborts++;
			testAborts++;
		end else begin
			for (int i = 0; i < robModel.size(); i++) begin
				if (wbValid && robModel[i].rg == wbReg && robModel[i].cp == wbCopy) begin
					e = robModel[i];
					e.done = 1'b1;
					robModel[i] = e;
				end
			end
			if (dispatchValid && !flushCycle) begin
				e = '{dispatchReg, expCopy, dispatchPc, dispatchBranch, dispatchStore,
					dispatchMisp, 1'b0};
				robModel.push_back(e);
				modelInUse[dispatchReg][expCopy] = 1'b1;
			end
		end
		flushCycle = expAbort;
		@(posedge clk);
		#1;
		dispatchValid = 1'b0;
		wbValid = 1'b0;
		isMisPredict = 1'b0;
		isAsynExcept = 1'b0;
		dispatchMisp = 1'b0;
	endtask

	// Waits for a credit; with none left, the head gets its writeback so it can retire.
	task automatic dispatchOne(stepT s);
		int n;
		n = 0;
		while ((credits == 0 || flushCycle) && !hung) begin
			if (n == WAIT_LIMIT) markTimeout("credit return");
			else begin
				if (credits == 0 && robModel.size() > 0 && !robModel[0].done) driveWriteback(0);
				tick();
			end
			n++;
		end
		if (!hung) begin
			dispatchValid = 1'b1;
			dispatchPc = s.pc;
			dispatchReg = s.rg;
			dispatchBranch = s.br;
			dispatchStore = s.st;
			dispatchMisp = s.misp;
			tick();
		end
	endtask

	// Writebacks in LFSR order until empty.
	// A marked branch holds isMisPredict up while in flight, and aborts once done at the head.
	task automatic drainAll();
		int   n;
		int   idx;
		logic mispInFlight;
		n = 0;
		while (robModel.size() != 0 && !hung) begin
			if (n == WAIT_LIMIT) markTimeout("drain of the reorder FIFO");
			else begin
				mispInFlight = 1'b0;
				for (int i = 0; i < robModel.size(); i++) begin
					if (robModel[i].br && robModel[i].misp) mispInFlight = 1'b1;
				end
				isMisPredict = mispInFlight;
				if (!(robModel[0].done && robModel[0].br && robModel[0].misp)) begin
					idx = pickPending();
					if (idx >= 0) driveWriteback(idx);
				end
				tick();
			end
			n++;
		end
	endtask

	// Head is made ready first, so the exception lands in a cycle that would commit.
	task automatic asyncAbort();
		if (robModel.size() != 0 && !robModel[0].done) driveWriteback(0);
		tick();
		isAsynExcept = 1'b1;
		tick();
	endtask

	task automatic loadTable();
		steps[0]  = '{4'd1, 5'd3,  64'h100, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		// Back-to-back dispatch to one register.
		steps[1]  = '{4'd2, 5'd1,  64'h104, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[2]  = '{4'd2, 5'd1,  64'h108, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[3]  = '{4'd2, 5'd4,  64'h10c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		// Four entries spend every credit.
		steps[4]  = '{4'd3, 5'd6,  64'h200, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[5]  = '{4'd3, 5'd7,  64'h204, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[6]  = '{4'd3, 5'd8,  64'h208, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[7]  = '{4'd3, 5'd9,  64'h20c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[8]  = '{4'd3, 5'd10, 64'h210, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		steps[9]  = '{4'd4, 5'd5,  64'h300, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		steps[10] = '{4'd4, 5'd5,  64'h304, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		// Branch at 404 mispredicts.
		steps[11] = '{4'd5, 5'd11, 64'h400, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[12] = '{4'd5, 5'd12, 64'h404, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
		steps[13] = '{4'd5, 5'd11, 64'h408, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
		steps[14] = '{4'd5, 5'd11, 64'h40c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		// Store commit, then an async exception.
		steps[15] = '{4'd6, 5'd14, 64'h500, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
		steps[16] = '{4'd6, 5'd16, 64'h504, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		steps[17] = '{4'd6, 5'd17, 64'h508, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
		steps[18] = '{4'd6, 5'd16, 64'h50c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	endtask

	// ##############################
	// Main sequence.
	// ##############################

	initial begin
		rstN = 1'b0;
		dispatchValid = 1'b0;
		dispatchPc = '0;
		dispatchReg = '0;
		dispatchBranch = 1'b0;
		dispatchStore = 1'b0;
		wbValid = 1'b0;
		wbReg = '0;
		wbCopy = '0;
		isMisPredict = 1'b0;
		isAsynExcept = 1'b0;
		dispatchMisp = 1'b0;
		flushCycle = 1'b0;
		hung = 1'b0;
		lfsr = 32'h153d;
		credits = ROB_DEPTH;
		{errors, commits, aborts, testErrors, testCommits, testAborts} = '0;
		curTest = 1;
		// Copy 0 of every register starts committed.
		for (int r = 0; r < ARCH_REGS; r++) begin
			modelCommitted[r] = '0;
			modelInUse[r] = copyMaskT'(1);
		end
		loadTable();
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(negedge clk);
		if (commitValid !== 1'b0 || commitAbort !== 1'b0 || creditReturn !== 1'b0
			|| suReady !== 1'b0)
			reportError("commit outputs not low after reset");
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_STEPS && !hung; i++) begin
			curTest = int'(steps[i].test);
			abortsBefore = aborts;
			dispatchOne(steps[i]);
			if (steps[i].drain) drainAll();
			if (steps[i].exc) asyncAbort();
			if ((steps[i].drain || steps[i].exc) && !hung) begin
				if ((aborts != abortsBefore) != steps[i].expAbort)
					reportError($sformatf("step %0d abort seen %b, expected %b",
						i, aborts != abortsBefore, steps[i].expAbort));
				if (aborts != abortsBefore && credits != ROB_DEPTH)
					reportError($sformatf("credits %0d after abort, expected %0d",
						credits, ROB_DEPTH));
			end
			if (i == NUM_STEPS - 1 || steps[i + 1].test != steps[i].test) begin
				$display("Test %0d finished: %0d commits, %0d aborts, %0d errors",
					curTest, testCommits, testAborts, testErrors);
				{testErrors, testCommits, testAborts} = '0;
			end
		end
		$display("Totals: %0d commits, %0d aborts, %0d errors", commits, aborts, errors);
		if (errors == 0 && !hung) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* verilog/commitCore.sv */
// Sender must honor credits; writebacks may only target copies in flight.
module commitCore (
	input  logic               clk,
	input  logic               rstN,
	input  logic               dispatchValid,
	input  renamePkg::pcT      dispatchPc,
	input  renamePkg::regIdxT  dispatchReg,
	input  logic               dispatchBranch,
	input  logic               dispatchStore,
	input  logic               wbValid,
	input  renamePkg::regIdxT  wbReg,
	input  renamePkg::copyIdxT wbCopy,
	input  logic               isMisPredict,
	input  logic               isAsynExcept,
	output renamePkg::copyIdxT dispatchCopy,
	output logic               creditReturn,
	output logic               commitValid,
	output renamePkg::pcT      commitPc,
	output renamePkg::regIdxT  commitReg,
	output renamePkg::copyIdxT commitCopy,
	output logic               commitAbort,
	output logic               suReady
);
	import renamePkg::*;

	// ##############################
	// Internal wires.
	// ##############################

	// Rename to register state and FIFO.
	logic     allocValid;
	regIdxT   allocReg;
	copyIdxT  allocCopy;
	copyMaskT inUseMask;

	// FIFO head to commit unit.
	logic     headValid;
	pcT       headPc;
	regIdxT   headReg;
	copyIdxT  headCopy;
	logic     headBranch;
	logic     headStore;
	logic     headWritten;

	// Commit unit controls.
	logic     pop;
	logic     flush;
	logic     flushing;

	renameAlloc uRename (
		.clk, .rstN, .dispatchValid, .dispatchReg, .inUseMask, .flushing,
		.dispatchCopy, .allocValid, .allocReg, .allocCopy
	);

	// Push follows the allocation so flush cycles drop dispatch.
	reorderFifo uFifo (
		.clk, .rstN, .push(allocValid), .pushPc(dispatchPc), .pushReg(allocReg),
		.pushCopy(allocCopy), .pushBranch(dispatchBranch), .pushStore(dispatchStore),
		.pop, .flush, .headValid, .headPc, .headReg, .headCopy, .headBranch,
		.headStore, .creditReturn
	);

	regState uState (
		.clk, .rstN, .allocValid, .allocReg, .allocCopy, .wbValid, .wbReg, .wbCopy,
		.queryReg(dispatchReg), .headReg, .headCopy, .commitValid, .commitReg,
		.commitCopy, .flush, .inUseMask, .headWritten
	);

	commitUnit uCommit (
		.clk, .rstN, .headValid, .headPc, .headReg, .headCopy, .headBranch,
		.headStore, .headWritten, .isMisPredict, .isAsynExcept, .commitValid,
		.commitPc, .commitReg, .commitCopy, .commitAbort, .suReady, .pop, .flush,
		.flushing
	);

endmodule

/* verilog/commitUnit.sv */
// Only branch mispredicts and async exceptions abort; no synchronous traps.
module commitUnit (
	input  logic               clk,
	input  logic               rstN,
	input  logic               headValid,
	input  renamePkg::pcT      headPc,
	input  renamePkg::regIdxT  headReg,
	input  renamePkg::copyIdxT headCopy,
	input  logic               headBranch,
	input  logic               headStore,
	input  logic               headWritten,
	input  logic               isMisPredict,
	input  logic               isAsynExcept,
	output logic               commitValid,
	output renamePkg::pcT      commitPc,
	output renamePkg::regIdxT  commitReg,
	output renamePkg::copyIdxT commitCopy,
	output logic               commitAbort,
	output logic               suReady,
	output logic               pop,
	output logic               flush,
	output logic               flushing
);
	import renamePkg::*;

	commitStateT state;
	commitStateT stateNext;
	logic        headDone;

	// Head has its result.
	assign headDone = headValid & headWritten;

	// ##############################
	// Commit and abort decision.
	// ##############################

	// Branch aborts only once resolved and written back.
	assign commitAbort = isAsynExcept | (headDone & headBranch & isMisPredict);
	assign commitValid = headDone & ~commitAbort & (state == cRun);
	assign commitPc = headPc;
	assign commitReg = headReg;
	assign commitCopy = headCopy;
	assign suReady = commitValid & headStore;
	assign pop = commitValid;
	assign flush = commitAbort;
	assign flushing = (state == cFlush);

	// FSM.
	always_comb begin
		stateNext = state;
		case (state)
			cIdle: stateNext = cRun;
			cRun: if (commitAbort) stateNext = cFlush;
			cFlush: stateNext = commitAbort ? cFlush : cRun;
			default: stateNext = cIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= cIdle;
		end else begin
			state <= stateNext;
		end
	end

	// Abort leaves the FIFO empty for the flush cycle.
	assert property (@(posedge clk) disable iff (!rstN)
		commitAbort |=> (state == cFlush && !headValid))
		else $error("Reorder FIFO not empty after abort.");

endmodule

/* verilog/regState.sv */
// Tracks copy bookkeeping only; register values live outside this block.
module regState (
	input  logic                clk,
	input  logic                rstN,
	input  logic                allocValid,
	input  renamePkg::regIdxT   allocReg,
	input  renamePkg::copyIdxT  allocCopy,
	input  logic                wbValid,
	input  renamePkg::regIdxT   wbReg,
	input  renamePkg::copyIdxT  wbCopy,
	input  renamePkg::regIdxT   queryReg,
	input  renamePkg::regIdxT   headReg,
	input  renamePkg::copyIdxT  headCopy,
	input  logic                commitValid,
	input  renamePkg::regIdxT   commitReg,
	input  renamePkg::copyIdxT  commitCopy,
	input  logic                flush,
	output renamePkg::copyMaskT inUseMask,
	output logic                headWritten
);
	import renamePkg::*;

	// ##############################
	// State arrays.
	// ##############################

	// Committed copy of each register.
	copyIdxT  committed [ARCH_REGS];
	// Written-back log per copy.
	copyMaskT written [ARCH_REGS];
	// Copies held by the committed state or by in-flight entries.
	copyMaskT inUse [ARCH_REGS];

	copyIdxT  committedNext [ARCH_REGS];
	copyMaskT writtenNext [ARCH_REGS];
	copyMaskT inUseNext [ARCH_REGS];

	// Next-state per register.
	always_comb begin
		for (int r = 0; r < ARCH_REGS; r++) begin
			committedNext[r] = committed[r];
			writtenNext[r] = written[r];
			inUseNext[r] = inUse[r];
			if (flush) begin
				// Only the committed copy survives.
				writtenNext[r] = copyMaskT'(1) << committed[r];
				inUseNext[r] = copyMaskT'(1) << committed[r];
			end else begin
				if (allocValid && allocReg == regIdxT'(r)) begin
					inUseNext[r] = inUseNext[r] | (copyMaskT'(1) << allocCopy);
				end
				if (wbValid && wbReg == regIdxT'(r)) begin
					writtenNext[r] = writtenNext[r] | (copyMaskT'(1) << wbCopy);
				end
				// Commit frees the old copy and keeps the new one.
				if (commitValid && commitReg == regIdxT'(r)) begin
					committedNext[r] = commitCopy;
					inUseNext[r] = inUseNext[r] & ~(copyMaskT'(1) << committed[r]);
					writtenNext[r] = writtenNext[r] & ~(copyMaskT'(1) << committed[r]);
				end
			end
		end
	end

	// Copy 0 starts committed and written back.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int r = 0; r < ARCH_REGS; r++) begin
				committed[r] <= '0;
				written[r] <= copyMaskT'(1);
				inUse[r] <= copyMaskT'(1);
			end
		end else begin
			committed <= committedNext;
			written <= writtenNext;
			inUse <= inUseNext;
		end
	end

	// Read ports.
	assign inUseMask = inUse[queryReg];
	assign headWritten = written[headReg][headCopy];

	assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> (inUse[wbReg][wbCopy] && !written[wbReg][wbCopy]))
		else $error("Writeback to register %0d copy %0d not in flight.", wbReg, wbCopy);

endmodule

/* verilog/reorderFifo.sv */
// No back-pressure here; the sender's credits must keep pushes off a full FIFO.
module reorderFifo (
	input  logic               clk,
	input  logic               rstN,
	input  logic               push,
	input  renamePkg::pcT      pushPc,
	input  renamePkg::regIdxT  pushReg,
	input  renamePkg::copyIdxT pushCopy,
	input  logic               pushBranch,
	input  logic               pushStore,
	input  logic               pop,
	input  logic               flush,
	output logic               headValid,
	output renamePkg::pcT      headPc,
	output renamePkg::regIdxT  headReg,
	output renamePkg::copyIdxT headCopy,
	output logic               headBranch,
	output logic               headStore,
	output logic               creditReturn
);
	import renamePkg::*;

	// ##############################
	// Storage.
	// ##############################

	pcT      pcMem [ROB_DEPTH];
	regIdxT  regMem [ROB_DEPTH];
	copyIdxT copyMem [ROB_DEPTH];
	logic    branchMem [ROB_DEPTH];
	logic    storeMem [ROB_DEPTH];

	robPtrT  wrPtr;
	robPtrT  rdPtr;
	logic    empty;
	logic    full;

	// Same slot with opposite wrap bits means full.
	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[ROB_AW] != rdPtr[ROB_AW])
		&& (wrPtr[ROB_AW-1:0] == rdPtr[ROB_AW-1:0]);

	always_ff @(posedge clk) begin
		if (push) begin
			pcMem[wrPtr[ROB_AW-1:0]] <= pushPc;
			regMem[wrPtr[ROB_AW-1:0]] <= pushReg;
			copyMem[wrPtr[ROB_AW-1:0]] <= pushCopy;
			branchMem[wrPtr[ROB_AW-1:0]] <= pushBranch;
			storeMem[wrPtr[ROB_AW-1:0]] <= pushStore;
		end
	end

	// ##############################
	// Pointers.
	// ##############################

	// Flush drops every entry, including a push in the same cycle.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else if (flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + robPtrT'(1);
			if (pop) rdPtr <= rdPtr + robPtrT'(1);
		end
	end

	// Head entry.
	assign headValid = ~empty;
	assign headPc = pcMem[rdPtr[ROB_AW-1:0]];
	assign headReg = regMem[rdPtr[ROB_AW-1:0]];
	assign headCopy = copyMem[rdPtr[ROB_AW-1:0]];
	assign headBranch = branchMem[rdPtr[ROB_AW-1:0]];
	assign headStore = storeMem[rdPtr[ROB_AW-1:0]];

	// One credit back per retired entry.
	assign creditReturn = pop;

	assert property (@(posedge clk) disable iff (!rstN) (push && !flush) |-> !full)
		else $error("Dispatch pushed into a full reorder FIFO.");
	assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
		else $error("Commit popped an empty reorder FIFO.");

endmodule

/* verilog/renameAlloc.sv */
// Rename never stalls; the sender must keep dispatch within its credits.
module renameAlloc (
	input  logic                clk,
	input  logic                rstN,
	input  logic                dispatchValid,
	input  renamePkg::regIdxT   dispatchReg,
	input  renamePkg::copyMaskT inUseMask,
	input  logic                flushing,
	output renamePkg::copyIdxT  dispatchCopy,
	output logic                allocValid,
	output renamePkg::regIdxT   allocReg,
	output renamePkg::copyIdxT  allocCopy
);
	import renamePkg::*;

	copyMaskT freeMask;
	logic     found;

	// In-use bits are set at the allocating edge.
	// Back-to-back dispatches to one register therefore see the copy just taken.
	assign freeMask = ~inUseMask;

	// Priority encoder.
	// Lowest free copy wins.
	always_comb begin
		dispatchCopy = '0;
		found = 1'b0;
		for (int i = COPIES - 1; i >= 0; i--) begin
			if (freeMask[i]) begin
				dispatchCopy = copyIdxT'(i);
				found = 1'b1;
			end
		end
	end

	// Dispatch is dropped while the core flushes.
	assign allocValid = dispatchValid & ~flushing;
	assign allocReg = dispatchReg;
	assign allocCopy = dispatchCopy;

	// A four-deep FIFO leaves at least three spare copies per register.
	assert property (@(posedge clk) disable iff (!rstN) allocValid |-> found)
		else $error("Rename found no free copy for register %0d.", dispatchReg);

endmodule

/* verilog/renamePkg.sv */
// Sizes assume 32 registers with eight copies each and a four-entry reorder FIFO.
package renamePkg;

	// ##############################
	// Core sizes.
	// ##############################

	// Architectural register file.
	localparam int ARCH_REGS = 32;
	// Physical copies kept for each register.
	localparam int COPIES = 8;
	// Reorder FIFO depth, also the sender's starting credit count.
	localparam int ROB_DEPTH = 4;
	// Derived widths.
	localparam int REG_W = $clog2(ARCH_REGS);
	localparam int COPY_W = $clog2(COPIES);
	localparam int ROB_AW = $clog2(ROB_DEPTH);
	localparam int PC_W = 64;

	// ##############################
	// Typed vectors.
	// ##############################

	typedef logic [REG_W-1:0] regIdxT;
	typedef logic [COPY_W-1:0] copyIdxT;
	typedef logic [COPIES-1:0] copyMaskT;
	typedef logic [PC_W-1:0] pcT;
	// Pointer carries one extra wrap bit.
	typedef logic [ROB_AW:0] robPtrT;

	// Commit unit states.
	typedef enum logic [1:0] {
		cIdle,
		cRun,
		cFlush
	} commitStateT;

endpackage
